// ==== src/cache_cfg_pkg.sv ====
/*
 * instruction cache geometry constants, tag entry and fetch port structs,
 * controller state encoding
 */

`default_nettype none

package cache_cfg_pkg;

    localparam int ADDR_W   = 32;
    localparam int WORD_W   = 32;
    localparam int BLOCK_W  = 128;  // four words per block
    localparam int OFFSET_W = 4;    // byte offset inside a block

    // tag keeps every bit above the offset, so the set count is free
    localparam int TAG_W = ADDR_W - OFFSET_W;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic              req;   // held until data_rdy
        logic [ADDR_W-1:0] addr;
    } fetch_req_t;

    typedef struct packed {
        logic              data_rdy;    // one-cycle pulse
        logic              miss_stall;  // level while a refill is pending
        logic [WORD_W-1:0] data;
    } fetch_resp_t;

    typedef enum logic [2:0] {
        IC_IDLE,
        IC_LOOKUP,
        IC_WAIT_BUSY,
        IC_REFILL,
        IC_FILL
    } ic_state_e;

endpackage

`default_nettype wire

// ==== src/l2_bus_pkg.sv ====
/*
 * refill bus request and response structs, arbiter state encoding
 */

`default_nettype none

package l2_bus_pkg;

    typedef struct packed {
        logic                             req;       // level, held until rdy
        logic [cache_cfg_pkg::TAG_W-1:0]  blk_addr;  // address bits above offset
    } l2_req_t;

    typedef struct packed {
        logic                               rdy;   // pulse with the block
        logic                               busy;
        logic [cache_cfg_pkg::BLOCK_W-1:0]  data;
    } l2_resp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_GRANT0,
        ARB_GRANT1
    } arb_state_e;

endpackage

`default_nettype wire

// ==== src/icache_ctrl.sv ====
/*
 * instruction cache controller: lookup, miss handling, refill sequencing
 * and word select for one fetch port
 */

`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
    parameter int SETS = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  cache_cfg_pkg::fetch_req_t          fetch,
    output cache_cfg_pkg::fetch_resp_t         rsp,
    output logic [$clog2(SETS)-1:0]            rd_index,
    input  cache_cfg_pkg::tag_entry_t          tag0,
    input  cache_cfg_pkg::tag_entry_t          tag1,
    input  logic [cache_cfg_pkg::BLOCK_W-1:0]  blk0,
    input  logic [cache_cfg_pkg::BLOCK_W-1:0]  blk1,
    input  logic                               lru,
    output logic                               wr_en,
    output logic                               wr_way,
    output cache_cfg_pkg::tag_entry_t          wr_tag,
    output logic [cache_cfg_pkg::BLOCK_W-1:0]  wr_blk,
    output logic                               touch_en,
    output logic                               touch_way,
    output l2_bus_pkg::l2_req_t                l2_req,
    input  l2_bus_pkg::l2_resp_t               l2_rsp
);

    localparam int IDX_W = $clog2(SETS);

    cache_cfg_pkg::ic_state_e                state, next_state;
    logic [cache_cfg_pkg::ADDR_W-1:0]        addr_q;
    logic [cache_cfg_pkg::BLOCK_W-1:0]       refill_blk;
    cache_cfg_pkg::fetch_resp_t              rsp_q;
    logic [cache_cfg_pkg::TAG_W-1:0]         addr_tag;
    logic [1:0]                              word_sel;
    logic                                    hit0, hit1, hit;
    logic                                    victim;
    logic                                    accept;

    function automatic logic [cache_cfg_pkg::WORD_W-1:0] pick_word(
        input logic [cache_cfg_pkg::BLOCK_W-1:0] blk,
        input logic [1:0]                        sel
    );
        pick_word = blk[sel * cache_cfg_pkg::WORD_W +: cache_cfg_pkg::WORD_W];
    endfunction

    assign addr_tag = addr_q[cache_cfg_pkg::ADDR_W-1:cache_cfg_pkg::OFFSET_W];
    assign word_sel = addr_q[3:2];

    // no new request in the pulse cycle, the core still holds the old one
    assign accept = (state == cache_cfg_pkg::IC_IDLE) && fetch.req && !rsp_q.data_rdy;

    // ways read one cycle ahead, so idle looks at the live address
    assign rd_index = (state == cache_cfg_pkg::IC_IDLE) ?
                      fetch.addr[cache_cfg_pkg::OFFSET_W +: IDX_W] :
                      addr_q[cache_cfg_pkg::OFFSET_W +: IDX_W];

    assign hit0 = tag0.valid && (tag0.tag == addr_tag);
    assign hit1 = tag1.valid && (tag1.tag == addr_tag);
    assign hit  = hit0 || hit1;

    // invalid way 0 first, then invalid way 1, else the lru way
    assign victim = !tag0.valid ? 1'b0 : (!tag1.valid ? 1'b1 : lru);

    always_comb begin
        next_state = state;
        case (state)
            cache_cfg_pkg::IC_IDLE: begin
                if (accept) next_state = cache_cfg_pkg::IC_LOOKUP;
            end
            cache_cfg_pkg::IC_LOOKUP: begin
                if (hit)
                    next_state = cache_cfg_pkg::IC_IDLE;
                else if (l2_rsp.busy)
                    next_state = cache_cfg_pkg::IC_WAIT_BUSY;
                else
                    next_state = cache_cfg_pkg::IC_REFILL;
            end
            cache_cfg_pkg::IC_WAIT_BUSY: begin
                if (!l2_rsp.busy) next_state = cache_cfg_pkg::IC_REFILL;
            end
            cache_cfg_pkg::IC_REFILL: begin
                if (l2_rsp.rdy) next_state = cache_cfg_pkg::IC_FILL;
            end
            cache_cfg_pkg::IC_FILL: next_state = cache_cfg_pkg::IC_IDLE;
            default: next_state = cache_cfg_pkg::IC_IDLE;
        endcase
    end

    assign touch_en  = (state == cache_cfg_pkg::IC_LOOKUP) && hit;
    assign touch_way = !hit0;  // way 1 when way 0 missed

    assign wr_en        = (state == cache_cfg_pkg::IC_FILL);
    assign wr_way       = victim;
    assign wr_tag.valid = 1'b1;
    assign wr_tag.tag   = addr_tag;
    assign wr_blk       = refill_blk;

    assign l2_req.req      = (state == cache_cfg_pkg::IC_REFILL);  // held until rdy
    assign l2_req.blk_addr = addr_tag;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= cache_cfg_pkg::IC_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= fetch.addr;
        if ((state == cache_cfg_pkg::IC_REFILL) && l2_rsp.rdy) begin
            refill_blk <= l2_rsp.data;  // only valid during the pulse
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_q.data_rdy   <= 1'b0;
            rsp_q.miss_stall <= 1'b0;
        end else begin
            rsp_q.data_rdy <= 1'b0;
            if (state == cache_cfg_pkg::IC_LOOKUP) begin
                if (hit) begin
                    rsp_q.data_rdy <= 1'b1;
                    rsp_q.data     <= pick_word(hit0 ? blk0 : blk1, word_sel);
                end else begin
                    rsp_q.miss_stall <= 1'b1;
                end
            end else if (state == cache_cfg_pkg::IC_FILL) begin
                rsp_q.data_rdy   <= 1'b1;  // stall drops with the pulse
                rsp_q.miss_stall <= 1'b0;
                rsp_q.data       <= pick_word(refill_blk, word_sel);
            end
        end
    end

    assign rsp = rsp_q;

endmodule

`default_nettype wire

// ==== src/icache_ways.sv ====
/*
 * two-way tag and data storage with one lru bit per set, registered reads
 */

`timescale 1ns/1ps
`default_nettype none

module icache_ways #(
    parameter int SETS = 16
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [$clog2(SETS)-1:0]            rd_index,
    output cache_cfg_pkg::tag_entry_t          tag0,
    output cache_cfg_pkg::tag_entry_t          tag1,
    output logic [cache_cfg_pkg::BLOCK_W-1:0]  blk0,
    output logic [cache_cfg_pkg::BLOCK_W-1:0]  blk1,
    output logic                               lru,
    input  logic                               wr_en,
    input  logic                               wr_way,
    input  cache_cfg_pkg::tag_entry_t          wr_tag,
    input  logic [cache_cfg_pkg::BLOCK_W-1:0]  wr_blk,
    input  logic                               touch_en,
    input  logic                               touch_way
);

    logic [cache_cfg_pkg::TAG_W-1:0]    tag_mem0  [SETS];
    logic [cache_cfg_pkg::TAG_W-1:0]    tag_mem1  [SETS];
    logic [cache_cfg_pkg::BLOCK_W-1:0]  data_mem0 [SETS];
    logic [cache_cfg_pkg::BLOCK_W-1:0]  data_mem1 [SETS];
    logic [SETS-1:0]                    valid0, valid1;
    logic [SETS-1:0]                    lru_bits;  // names the way to replace next

    always_ff @(posedge clk) begin
        if (rst) begin
            valid0   <= '0;
            valid1   <= '0;
            lru_bits <= '0;
        end else if (wr_en) begin
            if (wr_way) valid1[rd_index] <= wr_tag.valid;
            else        valid0[rd_index] <= wr_tag.valid;
            lru_bits[rd_index] <= ~wr_way;  // point away from the filled way
        end else if (touch_en) begin
            lru_bits[rd_index] <= ~touch_way;
        end
    end

    // tag and block payload
    always_ff @(posedge clk) begin
        if (wr_en && !wr_way) begin
            tag_mem0[rd_index]  <= wr_tag.tag;
            data_mem0[rd_index] <= wr_blk;
        end
        if (wr_en && wr_way) begin
            tag_mem1[rd_index]  <= wr_tag.tag;
            data_mem1[rd_index] <= wr_blk;
        end
    end

    // read port, old data on a same-cycle write
    always_ff @(posedge clk) begin
        tag0.valid <= valid0[rd_index];
        tag0.tag   <= tag_mem0[rd_index];
        tag1.valid <= valid1[rd_index];
        tag1.tag   <= tag_mem1[rd_index];
        blk0       <= data_mem0[rd_index];
        blk1       <= data_mem1[rd_index];
        lru        <= lru_bits[rd_index];
    end

endmodule

`default_nettype wire

// ==== src/l2_arbiter.sv ====
/*
 * round-robin arbiter sharing one refill port between two caches
 */

`timescale 1ns/1ps
`default_nettype none

module l2_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  l2_bus_pkg::l2_req_t   req0,
    input  l2_bus_pkg::l2_req_t   req1,
    output l2_bus_pkg::l2_resp_t  rsp0,
    output l2_bus_pkg::l2_resp_t  rsp1,
    output l2_bus_pkg::l2_req_t   mem_req,
    input  l2_bus_pkg::l2_resp_t  mem_rsp
);

    l2_bus_pkg::arb_state_e state, next_state;
    logic                   last_served;  // cache that got the previous grant

    always_comb begin
        next_state = state;
        case (state)
            l2_bus_pkg::ARB_IDLE: begin
                if (req0.req && req1.req)  // favour the one not served last
                    next_state = last_served ? l2_bus_pkg::ARB_GRANT0 : l2_bus_pkg::ARB_GRANT1;
                else if (req0.req)
                    next_state = l2_bus_pkg::ARB_GRANT0;
                else if (req1.req)
                    next_state = l2_bus_pkg::ARB_GRANT1;
            end
            l2_bus_pkg::ARB_GRANT0,
            l2_bus_pkg::ARB_GRANT1: begin
                if (mem_rsp.rdy) next_state = l2_bus_pkg::ARB_IDLE;  // grant ends with the pulse
            end
            default: next_state = l2_bus_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= l2_bus_pkg::ARB_IDLE;
            last_served <= 1'b0;
        end else begin
            state <= next_state;
            if (mem_rsp.rdy) last_served <= (state == l2_bus_pkg::ARB_GRANT1);
        end
    end

    assign mem_req = (state == l2_bus_pkg::ARB_GRANT0) ? req0 :
                     (state == l2_bus_pkg::ARB_GRANT1) ? req1 : '0;

    assign rsp0.rdy  = (state == l2_bus_pkg::ARB_GRANT0) && mem_rsp.rdy;
    assign rsp0.busy = (state == l2_bus_pkg::ARB_GRANT1) || mem_rsp.busy;
    assign rsp0.data = (state == l2_bus_pkg::ARB_GRANT0) ? mem_rsp.data : '0;

    assign rsp1.rdy  = (state == l2_bus_pkg::ARB_GRANT1) && mem_rsp.rdy;
    assign rsp1.busy = (state == l2_bus_pkg::ARB_GRANT0) || mem_rsp.busy;
    assign rsp1.data = (state == l2_bus_pkg::ARB_GRANT1) ? mem_rsp.data : '0;

endmodule

`default_nettype wire

// ==== src/l2_backing_mem.sv ====
/*
 * block-wide backing memory with fixed read latency and a load port
 */

`timescale 1ns/1ps
`default_nettype none

module l2_backing_mem #(
    parameter int MEM_BLOCKS = 256,
    parameter int L2_LATENCY = 4
) (
    input  logic                               clk,
    input  logic                               rst,
    input  l2_bus_pkg::l2_req_t                req,
    output l2_bus_pkg::l2_resp_t               rsp,
    input  logic                               load_en,
    input  logic [$clog2(MEM_BLOCKS)-1:0]      load_addr,
    input  logic [cache_cfg_pkg::BLOCK_W-1:0]  load_data
);

    localparam int MIDX_W = $clog2(MEM_BLOCKS);
    localparam int CNT_W  = $clog2(L2_LATENCY + 1);

    logic [cache_cfg_pkg::BLOCK_W-1:0]  mem [MEM_BLOCKS];
    logic [cache_cfg_pkg::BLOCK_W-1:0]  data_q;
    logic [MIDX_W-1:0]                  addr_q;
    logic [CNT_W-1:0]                   cnt;
    logic                               busy_q, rdy_q;
    logic                               accept;

    // the pulse cycle is not idle, the request level is still up then
    assign accept = req.req && !busy_q && !rdy_q;

    always_ff @(posedge clk) begin
        if (load_en) mem[load_addr] <= load_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            rdy_q  <= 1'b0;
            cnt    <= '0;
        end else begin
            rdy_q <= 1'b0;
            if (accept) begin
                busy_q <= 1'b1;
                cnt    <= CNT_W'(L2_LATENCY - 1);
            end else if (busy_q) begin
                if (cnt == '0) begin
                    busy_q <= 1'b0;
                    rdy_q  <= 1'b1;  // L2_LATENCY edges after accept
                end else begin
                    cnt <= cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) addr_q <= MIDX_W'(req.blk_addr % MEM_BLOCKS);  // wraps
        if (busy_q && (cnt == '0)) data_q <= mem[addr_q];
    end

    assign rsp.rdy  = rdy_q;
    assign rsp.busy = busy_q;
    assign rsp.data = data_q;

endmodule

`default_nettype wire

// ==== src/icache_pair_top.sv ====
/*
 * two instruction caches sharing one backing memory through an arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module icache_pair_top #(
    parameter int SETS       = 16,
    parameter int MEM_BLOCKS = 256,
    parameter int L2_LATENCY = 4
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  cache_cfg_pkg::fetch_req_t  [1:0]        fetch,
    output cache_cfg_pkg::fetch_resp_t [1:0]        rsp,
    input  logic                                    load_en,
    input  logic [$clog2(MEM_BLOCKS)-1:0]           load_addr,
    input  logic [cache_cfg_pkg::BLOCK_W-1:0]       load_data
);

    // one element per cache
    logic [$clog2(SETS)-1:0]            rd_index [2];
    cache_cfg_pkg::tag_entry_t          tag0 [2], tag1 [2], wr_tag [2];
    logic [cache_cfg_pkg::BLOCK_W-1:0]  blk0 [2], blk1 [2], wr_blk [2];
    logic                               lru [2], wr_en [2], wr_way [2];
    logic                               touch_en [2], touch_way [2];
    l2_bus_pkg::l2_req_t                l2_req [2];
    l2_bus_pkg::l2_resp_t               l2_rsp [2];
    l2_bus_pkg::l2_req_t                mem_req;
    l2_bus_pkg::l2_resp_t               mem_rsp;

    for (genvar i = 0; i < 2; i++) begin : gen_cache
        icache_ctrl #(.SETS(SETS)) ctrl_inst (
            .clk(clk), .rst(rst),
            .fetch(fetch[i]), .rsp(rsp[i]),
            .rd_index(rd_index[i]),
            .tag0(tag0[i]), .tag1(tag1[i]),
            .blk0(blk0[i]), .blk1(blk1[i]), .lru(lru[i]),
            .wr_en(wr_en[i]), .wr_way(wr_way[i]),
            .wr_tag(wr_tag[i]), .wr_blk(wr_blk[i]),
            .touch_en(touch_en[i]), .touch_way(touch_way[i]),
            .l2_req(l2_req[i]), .l2_rsp(l2_rsp[i])
        );

        icache_ways #(.SETS(SETS)) ways_inst (
            .clk(clk), .rst(rst),
            .rd_index(rd_index[i]),
            .tag0(tag0[i]), .tag1(tag1[i]),
            .blk0(blk0[i]), .blk1(blk1[i]), .lru(lru[i]),
            .wr_en(wr_en[i]), .wr_way(wr_way[i]),
            .wr_tag(wr_tag[i]), .wr_blk(wr_blk[i]),
            .touch_en(touch_en[i]), .touch_way(touch_way[i])
        );
    end

    l2_arbiter arbiter_inst (
        .clk(clk), .rst(rst),
        .req0(l2_req[0]), .req1(l2_req[1]),
        .rsp0(l2_rsp[0]), .rsp1(l2_rsp[1]),
        .mem_req(mem_req), .mem_rsp(mem_rsp)
    );

    l2_backing_mem #(
        .MEM_BLOCKS(MEM_BLOCKS),
        .L2_LATENCY(L2_LATENCY)
    ) mem_inst (
        .clk(clk), .rst(rst),
        .req(mem_req), .rsp(mem_rsp),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

endmodule

`default_nettype wire

// ==== verification/icache_tb.sv ====
/*
 * testbench for the instruction cache pair: memory load, random fetch
 * stimulus, reference cache model and response compare tasks
 */

`timescale 1ns/1ps
`default_nettype none

module icache_tb;

    localparam int SETS       = 16;
    localparam int MEM_BLOCKS = 256;
    localparam int L2_LATENCY = 4;
    localparam int LIMIT      = 200;  // cycles per wait loop
    localparam int IDX_W      = $clog2(SETS);
    localparam int MIDX_W     = $clog2(MEM_BLOCKS);

    logic                                    clk;
    logic                                    rst;
    cache_cfg_pkg::fetch_req_t  [1:0]        fetch;
    cache_cfg_pkg::fetch_resp_t [1:0]        rsp;
    logic                                    load_en;
    logic [MIDX_W-1:0]                       load_addr;
    logic [cache_cfg_pkg::BLOCK_W-1:0]       load_data;

    logic [cache_cfg_pkg::BLOCK_W-1:0]  mem_copy [MEM_BLOCKS];
    logic [cache_cfg_pkg::TAG_W-1:0]    m_tag   [2][SETS][2];
    bit                                 m_valid [2][SETS][2];
    bit                                 m_lru   [2][SETS];  // way to replace next
    integer                             seed;
    int                                 errors, checks, tests;
    int                                 last_port;  // port of the latest refill

    icache_pair_top #(
        .SETS(SETS),
        .MEM_BLOCKS(MEM_BLOCKS),
        .L2_LATENCY(L2_LATENCY)
    ) icache_pair_top_inst (
        .clk(clk), .rst(rst),
        .fetch(fetch), .rsp(rsp),
        .load_en(load_en), .load_addr(load_addr), .load_data(load_data)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [cache_cfg_pkg::BLOCK_W-1:0] blk;
        blk = mem_copy[addr[31:4] % MEM_BLOCKS];
        return blk[addr[3:2] * 32 +: 32];
    endfunction

    function automatic bit model_hit(input int p, input logic [31:0] addr);
        int s;
        s = int'(addr[4 +: IDX_W]);
        return (m_valid[p][s][0] && m_tag[p][s][0] == addr[31:4]) ||
               (m_valid[p][s][1] && m_tag[p][s][1] == addr[31:4]);
    endfunction

    // lookup with update, returns 1 on a hit
    function automatic bit model_access(input int p, input logic [31:0] addr);
        int s;
        int w;
        s = int'(addr[4 +: IDX_W]);
        for (w = 0; w < 2; w++) begin
            if (m_valid[p][s][w] && m_tag[p][s][w] == addr[31:4]) begin
                m_lru[p][s] = (w == 0);
                return 1'b1;
            end
        end
        if (!m_valid[p][s][0]) w = 0;
        else if (!m_valid[p][s][1]) w = 1;
        else w = int'(m_lru[p][s]);
        m_valid[p][s][w] = 1'b1;
        m_tag[p][s][w]   = addr[31:4];
        m_lru[p][s]      = (w == 0);
        return 1'b0;
    endfunction

    function automatic logic [31:0] random_addr();
        int blk_idx;
        int word;
        blk_idx = $random(seed) & 63;  // 4 tags per set, so sets collide
        word    = $random(seed) & 3;
        return 32'((blk_idx << 4) | (word << 2));
    endfunction

    task automatic check_idle(input cache_cfg_pkg::fetch_resp_t got, input int p);
        checks++;
        if (got.data_rdy !== 1'b0 || got.miss_stall !== 1'b0) begin
            $display("Fail %0t: port %0d active before any request", $time, p);
            errors++;
        end
    endtask

    task automatic check_word(input cache_cfg_pkg::fetch_resp_t got,
                              input logic [31:0] exp, input logic [31:0] addr);
        checks++;
        if (got.data !== exp) begin
            $display("Fail %0t: addr %h word %h expected %h", $time, addr, got.data, exp);
            errors++;
        end
    endtask

    task automatic check_kind(input cache_cfg_pkg::fetch_resp_t got, input bit exp_hit,
                              input bit saw_stall, input int cycles, input logic [31:0] addr);
        checks++;
        if (exp_hit && (saw_stall || got.miss_stall || cycles != 2)) begin
            $display("Fail %0t: addr %h hit took %0d cycles, stall %0b",
                     $time, addr, cycles, saw_stall);
            errors++;
        end else if (!exp_hit && (!saw_stall || got.miss_stall)) begin
            $display("Fail %0t: addr %h miss, stall before data %0b, stall with data %0b",
                     $time, addr, saw_stall, got.miss_stall);
            errors++;
        end
    endtask

    // called at a falling edge, returns at a falling edge after one idle cycle
    task automatic do_fetch(input int p, input logic [31:0] addr, input int exp_kind,
                            output time t_done);
        cache_cfg_pkg::fetch_resp_t got;
        logic [31:0]                exp_word;
        bit                         exp_hit;
        bit                         saw_stall;
        bit                         done;
        int                         n;
        exp_word       = expected_word(addr);
        exp_hit        = model_access(p, addr);
        fetch[p].req   = 1'b1;
        fetch[p].addr  = addr;
        saw_stall      = 1'b0;
        done           = 1'b0;
        n              = 0;
        got            = '0;
        while (!done && n < LIMIT) begin
            @(negedge clk);
            n++;
            got = rsp[p];
            if (got.data_rdy) done = 1'b1;
            else if (got.miss_stall) saw_stall = 1'b1;
        end
        fetch[p].req = 1'b0;
        t_done       = $time;
        if (!done) begin
            $display("timeout: port %0d fetch of %h never returned data", p, addr);
            errors++;
        end else begin
            check_word(got, exp_word, addr);
            check_kind(got, exp_hit, saw_stall, n, addr);
            if (!exp_hit) last_port = p;
            if (exp_kind >= 0 && exp_kind != int'(exp_hit)) begin
                $display("Fail %0t: addr %h eviction order broken in the model", $time, addr);
                errors++;
            end
        end
        @(negedge clk);
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        time         t0, t1;
        logic [31:0] a0, a1;
        int          e, i, tries, winner;
        clk = 1'b0;
        rst = 1'b1;
        fetch = '0;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        seed = 32'he3ff;
        errors = 0;
        checks = 0;
        tests = 0;
        last_port = 0;
        for (i = 0; i < 2 * SETS; i++) begin
            m_valid[i / SETS][i % SETS] = '{1'b0, 1'b0};
            m_lru[i / SETS][i % SETS]   = 1'b0;
        end

        e = errors;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_idle(rsp[0], 0);
            check_idle(rsp[1], 1);
        end
        report("reset", e);

        for (i = 0; i < MEM_BLOCKS; i++) begin
            mem_copy[i] = {$random(seed), $random(seed), $random(seed), $random(seed)};
            load_en   = 1'b1;
            load_addr = MIDX_W'(i);
            load_data = mem_copy[i];
            @(negedge clk);
        end
        load_en = 1'b0;
        @(negedge clk);

        // set 5 on port 0, blocks 5, 21 and 37 share it
        e = errors;
        do_fetch(0, 32'h0000_0050, 0, t0);
        do_fetch(0, 32'h0000_0154, 0, t0);
        do_fetch(0, 32'h0000_0058, 1, t0);
        do_fetch(0, 32'h0000_015c, 1, t0);
        do_fetch(0, 32'h0000_0250, 0, t0);  // replaces block 5
        do_fetch(0, 32'h0000_0158, 1, t0);
        do_fetch(0, 32'h0000_0054, 0, t0);
        report("eviction", e);

        e = errors;
        for (i = 0; i < 120; i++) begin
            do_fetch(i % 2, random_addr(), -1, t0);
        end
        report("random fetch", e);

        e = errors;
        for (i = 0; i < 12; i++) begin
            tries = 0;
            a0 = random_addr();
            a1 = random_addr();
            while ((model_hit(0, a0) || model_hit(1, a1)) && tries < 100) begin
                a0 = random_addr();
                a1 = random_addr();
                tries++;
            end
            if (tries >= 100) begin
                $display("no pair of missing addresses found in round %0d", i);
                errors++;
            end else begin
                winner = 1 - last_port;
                fork
                    do_fetch(0, a0, -1, t0);
                    do_fetch(1, a1, -1, t1);
                join
                checks++;
                if ((winner == 0 && t0 >= t1) || (winner == 1 && t1 >= t0)) begin
                    $display("Fail %0t: round %0d port %0d not served first",
                             $time, i, winner);
                    errors++;
                end
                last_port = 1 - winner;  // the other port refills second
            end
        end
        report("concurrent miss", e);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
src/cache_cfg_pkg.sv
src/l2_bus_pkg.sv
src/icache_ctrl.sv
src/icache_ways.sv
src/l2_arbiter.sv
src/l2_backing_mem.sv
src/icache_pair_top.sv
verification/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f tb.f --top-module icache_tb -o icache_sim \
    && ./obj_dir/icache_sim > sim.log 2>&1 \
    || { echo "build or run error"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
